//--- source/mix_pkg.sv
// shared types and constants; the input sample period must be at least OSR * TICK_DIV clocks
package mix_pkg;

	// FM sample as delivered by the synthesis core, two's complement
	typedef logic signed [8:0] fm_sample_t;

	// generator sample after zero extension of the 12-bit unsigned value
	typedef logic signed [12:0] gen_sample_t;

	// per-channel sum of FM and the attenuated generator
	// 9-bit FM plus a 7-bit positive generator term never exceeds 14 bits
	typedef logic signed [13:0] mix_t;

	// final stereo output word
	typedef logic signed [15:0] out_sample_t;

	// interpolation ratio, which is also the number of phases per input sample
	localparam int OSR = 4;

	// width of the phase index, log2 of OSR
	localparam int PHASE_W = 2;

	// clocks between two interpolation phases
	localparam int TICK_DIV = 8;

	// the interpolated generator is shifted right by this much before it is mixed in
	// so that a full scale square wave stays below the FM range
	localparam int GEN_SHIFT = 5;

	// width of the volume field, applied as a left shift of 0 to 7
	localparam int VOL_W = 3;

	// Wishbone word addresses of the register slave
	localparam logic [1:0] ADDR_VOLUME = 2'd0;
	localparam logic [1:0] ADDR_CTRL   = 2'd1;
	localparam logic [1:0] ADDR_STATUS = 2'd2;

endpackage

//--- source/mix_regs.sv
// Wishbone classic slave with one-cycle ack; any write to STATUS clears the sticky clip flag
`timescale 1ns/1ns

module mix_regs (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      cyc,
	input  logic                      stb,
	input  logic                      we,
	input  logic [1:0]                adr,
	input  logic [7:0]                dat_w,
	input  logic                      clip_left,
	input  logic                      clip_right,
	output logic [7:0]                dat_r,
	output logic                      ack,
	output logic [mix_pkg::VOL_W-1:0] volume,
	output logic                      gen_en
);
	import mix_pkg::*;

	logic       hs;
	logic       clip_flag;
	logic [7:0] rd_data;

	// a request is accepted only while ack is low, which limits ack to a single cycle
	assign hs = cyc & stb & ~ack;

	// read mux, unused bits and the unmapped address return zero
	always_comb begin
		rd_data = '0;
		case (adr)
			ADDR_VOLUME: rd_data[VOL_W-1:0] = volume;
			ADDR_CTRL:   rd_data[0] = gen_en;
			ADDR_STATUS: rd_data[0] = clip_flag;
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack       <= 1'b0;
			dat_r     <= '0;
			volume    <= '0;
			gen_en    <= 1'b0;
			clip_flag <= 1'b0;
		end else begin
			ack <= hs;
			// read data lands in the same cycle as ack
			if (hs) begin
				dat_r <= rd_data;
			end
			if (hs && we) begin
				case (adr)
					ADDR_VOLUME: volume <= dat_w[VOL_W-1:0];
					ADDR_CTRL:   gen_en <= dat_w[0];
					ADDR_STATUS: clip_flag <= 1'b0;
					default:     ;
				endcase
			end
			// a new clip in the clearing cycle wins so no event is lost
			if (clip_left || clip_right) begin
				clip_flag <= 1'b1;
			end
		end
	end

endmodule

//--- source/tick_timer.sv
// phase tick generator; free running between restarts, ticks during idle are ignored downstream
`timescale 1ns/1ns

module tick_timer (
	input  logic clk,
	input  logic arst_n,
	input  logic restart,
	output logic tick
);
	import mix_pkg::*;

	logic [$clog2(TICK_DIV)-1:0] cnt;

	// the restart cycle is itself a tick, so phase 0 lines up with the load
	assign tick = restart || (cnt == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (restart) begin
			// count from one so the next zero falls TICK_DIV clocks after the restart
			cnt <= 1;
		end else if (cnt == TICK_DIV - 1) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- source/interp_ctrl.sv
// phase sequencer; a strobe in any state restarts at phase 0 and drops the old phases
`timescale 1ns/1ns

module interp_ctrl (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        sample,
	input  logic                        tick,
	output logic                        restart,
	output logic                        load,
	output logic                        step,
	output logic [mix_pkg::PHASE_W-1:0] step_phase
);
	import mix_pkg::*;

	// run covers phases 0 to OSR-2, last waits for the final phase
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_LAST
	} state_t;

	state_t             state;
	logic [PHASE_W-1:0] phase;

	// step follows the tick in the same cycle, the interpolator registers on it
	assign step       = tick && (state != ST_IDLE);
	assign step_phase = phase;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			phase   <= '0;
			load    <= 1'b0;
			restart <= 1'b0;
		end else begin
			// load and restart both come one cycle after the strobe
			load    <= sample;
			restart <= sample;
			if (sample) begin
				state <= ST_RUN;
				phase <= '0;
			end else if (step) begin
				case (state)
					ST_RUN: begin
						phase <= phase + 1'b1;
						if (phase == PHASE_W'(OSR - 2)) begin
							state <= ST_LAST;
						end
					end
					ST_LAST: begin
						phase <= '0;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

endmodule

//--- source/lin_interp.sv
// linear x4 interpolator for one channel; output is floored toward minus infinity per phase
`timescale 1ns/1ns

module lin_interp #(
	parameter type sample_t = mix_pkg::fm_sample_t
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        sample,
	input  sample_t                     in_data,
	input  logic                        load,
	input  logic                        step,
	input  logic [mix_pkg::PHASE_W-1:0] step_phase,
	output sample_t                     out_data
);
	import mix_pkg::*;

	// the weighted sum is four times a value between prev and current
	// so two extra bits hold it without overflow
	typedef logic signed [$bits(sample_t)+1:0] wide_t;

	sample_t cap;
	sample_t prev;
	sample_t cur;
	sample_t prev_eff;
	sample_t cur_eff;
	wide_t   acc;

	// phase 0 steps in the load cycle, so the pair is taken as it will be after the load
	always_comb begin
		prev_eff = load ? cur : prev;
		cur_eff  = load ? cap : cur;
		// prev*(OSR-phase) + cur*phase equals OSR*prev + (cur-prev)*phase
		acc = wide_t'(prev_eff) * wide_t'(OSR - step_phase)
			+ wide_t'(cur_eff) * wide_t'(step_phase);
	end

	// sample capture and the interpolated result carry no reset
	always_ff @(posedge clk) begin
		if (sample) begin
			cap <= in_data;
		end
		// OSR*prev is a multiple of OSR, so the arithmetic shift floors only the slope term
		if (step) begin
			out_data <= sample_t'(acc >>> PHASE_W);
		end
	end

	// the endpoints start at zero so the first sample ramps up from silence
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev <= '0;
			cur  <= '0;
		end else if (load) begin
			prev <= cur;
			cur  <= cap;
		end
	end

endmodule

//--- source/gain_stage.sv
// per-channel mix, volume shift and 16-bit saturation; clip is a pulse with the clipped word
`timescale 1ns/1ns

module gain_stage (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      valid_in,
	input  mix_pkg::fm_sample_t       fm,
	input  mix_pkg::gen_sample_t      gen,
	input  logic [mix_pkg::VOL_W-1:0] volume,
	output mix_pkg::out_sample_t      out_data,
	output logic                      out_valid,
	output logic                      clip
);
	import mix_pkg::*;

	// room for the largest volume shift of the mixed value
	typedef logic signed [$bits(mix_t)+(2**VOL_W)-2:0] wide_t;

	mix_t        mix;
	wide_t       amp;
	logic        over;
	out_sample_t sat;

	always_comb begin
		// the generator term is always positive after the arithmetic shift
		mix = mix_t'(fm) + mix_t'(gen >>> GEN_SHIFT);
		amp = wide_t'(mix) <<< volume;
		// the value fits when every bit above the output sign matches it
		over = !((&amp[$bits(wide_t)-1:$bits(out_sample_t)-1])
			|| !(|amp[$bits(wide_t)-1:$bits(out_sample_t)-1]));
		if (!over) begin
			sat = out_sample_t'(amp);
		end else if (amp[$bits(wide_t)-1]) begin
			sat = {1'b1, {($bits(out_sample_t)-1){1'b0}}};
		end else begin
			sat = {1'b0, {($bits(out_sample_t)-1){1'b1}}};
		end
	end

	// the output word only changes with a valid sample
	always_ff @(posedge clk) begin
		if (valid_in) begin
			out_data <= sat;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			clip      <= 1'b0;
		end else begin
			out_valid <= valid_in;
			clip      <= valid_in && over;
		end
	end

endmodule

//--- source/audio_mixer.sv
// FM output stage top; no back-pressure, each input sample yields four outputs 8 clocks apart
`timescale 1ns/1ns

module audio_mixer (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [1:0]           adr,
	input  logic [7:0]           dat_w,
	output logic [7:0]           dat_r,
	output logic                 ack,
	input  logic                 sample,
	input  mix_pkg::fm_sample_t  left_in,
	input  mix_pkg::fm_sample_t  right_in,
	input  logic [11:0]          gen_in,
	output mix_pkg::out_sample_t left_out,
	output mix_pkg::out_sample_t right_out,
	output logic                 out_valid
);
	import mix_pkg::*;

	logic [VOL_W-1:0]   volume;
	logic               gen_en;
	logic               clip_left;
	logic               clip_right;
	logic               restart;
	logic               tick;
	logic               load;
	logic               step;
	logic               step_d;
	logic [PHASE_W-1:0] step_phase;
	gen_sample_t        gen_gated;
	fm_sample_t         fm_left;
	fm_sample_t         fm_right;
	gen_sample_t        gen_interp;

	// the enable gates the generator before interpolation so it fades out over one sample
	// the cast zero-extends the unsigned generator value into the signed type
	assign gen_gated = gen_sample_t'(gen_in & {12{gen_en}});

	// the interpolated values are valid one cycle after step
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_d <= 1'b0;
		end else begin
			step_d <= step;
		end
	end

	mix_regs u_regs (
		.clk(clk), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .clip_left(clip_left), .clip_right(clip_right),
		.dat_r(dat_r), .ack(ack), .volume(volume), .gen_en(gen_en)
	);

	tick_timer u_timer (.clk(clk), .arst_n(arst_n), .restart(restart), .tick(tick));

	interp_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n), .sample(sample), .tick(tick),
		.restart(restart), .load(load), .step(step), .step_phase(step_phase)
	);

	lin_interp #(.sample_t(fm_sample_t)) u_interp_left (
		.clk(clk), .arst_n(arst_n), .sample(sample), .in_data(left_in),
		.load(load), .step(step), .step_phase(step_phase), .out_data(fm_left)
	);

	lin_interp #(.sample_t(fm_sample_t)) u_interp_right (
		.clk(clk), .arst_n(arst_n), .sample(sample), .in_data(right_in),
		.load(load), .step(step), .step_phase(step_phase), .out_data(fm_right)
	);

	lin_interp #(.sample_t(gen_sample_t)) u_interp_gen (
		.clk(clk), .arst_n(arst_n), .sample(sample), .in_data(gen_gated),
		.load(load), .step(step), .step_phase(step_phase), .out_data(gen_interp)
	);

	// both channels share one valid, so the left stage drives out_valid
	gain_stage u_gain_left (
		.clk(clk), .arst_n(arst_n), .valid_in(step_d), .fm(fm_left), .gen(gen_interp),
		.volume(volume), .out_data(left_out), .out_valid(out_valid), .clip(clip_left)
	);

	gain_stage u_gain_right (
		.clk(clk), .arst_n(arst_n), .valid_in(step_d), .fm(fm_right), .gen(gen_interp),
		.volume(volume), .out_data(right_out), .out_valid(), .clip(clip_right)
	);

endmodule

//--- sim/audio_mixer_sva.sv
// bound checks on the Wishbone ack and the output spacing; inactive while arst_n is low
`timescale 1ns/1ns

module audio_mixer_sva (
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic load,
	input logic out_valid
);
	import mix_pkg::*;

	// the slave answers each request with a single-cycle ack
	ack_single: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> !$past(ack))
		else $error("ack stayed high for two cycles");

	// ack only answers a request seen on the previous edge
	ack_request: assert property (@(posedge clk) disable iff (!arst_n)
		ack |-> $past(cyc && stb))
		else $error("ack without a Wishbone request");

	// phase 0 comes two cycles after load, every later phase one tick after its predecessor
	valid_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !$past(load, 2)) |-> $past(out_valid, TICK_DIV))
		else $error("out_valid spacing differs from the tick period");

endmodule

bind audio_mixer audio_mixer_sva u_sva (
	.clk(clk), .arst_n(arst_n), .cyc(cyc), .stb(stb), .ack(ack),
	.load(load), .out_valid(out_valid)
);

//--- sim/tb_audio_mixer.sv
// outputs are read at the falling edge; only the restart test strobes faster than every 32 clocks
`timescale 1ns/1ns

module tb_audio_mixer;
	import mix_pkg::*;

	// 26 sample periods of about 33 clocks and 24 register cycles take under 1000 clocks
	// so this limit leaves a wide margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic clk = 1'b0;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [7:0] dat_w;
	logic [7:0] dat_r;
	logic ack;
	logic sample;
	fm_sample_t left_in;
	fm_sample_t right_in;
	logic [11:0] gen_in;
	out_sample_t left_out;
	out_sample_t right_out;
	logic out_valid;

	// reference state of the interpolators and the register fields
	int prev_l = 0;
	int cur_l = 0;
	int prev_r = 0;
	int cur_r = 0;
	int prev_g = 0;
	int cur_g = 0;
	int vol_m = 0;
	int gen_en_m = 0;
	int clip_m = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycles = 0;

	audio_mixer u_dut (
		.clk(clk), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .sample(sample), .left_in(left_in),
		.right_in(right_in), .gen_in(gen_in), .left_out(left_out),
		.right_out(right_out), .out_valid(out_valid)
	);

	always #20 clk = ~clk;

	// the run ends here if a handshake or an output never comes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// prev plus the floored share of the step for this phase
	function automatic int interp(input int prev, input int cur, input int phase);
		int d;
		int q;
		d = (cur - prev) * phase;
		q = d / OSR;
		if (d < 0 && q * OSR != d) begin
			q = q - 1;
		end
		return prev + q;
	endfunction

	// generator is never negative, so plain division matches the arithmetic shift
	function automatic int gain(input int fm, input int gen);
		return (fm + gen / (1 << GEN_SHIFT)) * (1 << vol_m);
	endfunction

	function automatic int saturate(input int amp);
		if (amp > 32767) begin
			return 32767;
		end else if (amp < -32768) begin
			return -32768;
		end
		return amp;
	endfunction

	function automatic int rand_fm();
		return int'($urandom % 512) - 256;
	endfunction

	// one classic cycle; the request is held until ack, then ack must drop a cycle later
	task automatic wb_cycle(input logic write, input int addr, input int wdata, output int rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr[1:0];
		dat_w <= wdata[7:0];
		do begin
			@(negedge clk);
			waited++;
		end while (!ack && waited < 4);
		rdata = int'(dat_r);
		if (!ack) begin
			errors++;
			$display("no Wishbone ack within 4 cycles at address %0d", addr);
		end
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		@(negedge clk);
		check("ack width", 0, int'(ack));
	endtask

	task automatic wb_write(input int addr, input int wdata);
		int unused;
		wb_cycle(1'b1, addr, wdata, unused);
		case (addr)
			0: vol_m = wdata % 8;
			1: gen_en_m = wdata % 2;
			2: clip_m = 0;
			default: ;
		endcase
	endtask

	task automatic wb_read(input int addr, output int rdata);
		wb_cycle(1'b0, addr, 0, rdata);
	endtask

	// one-cycle strobe; the model shifts current into previous like the interpolators
	task automatic strobe(input int l, input int r, input int g);
		@(posedge clk);
		sample <= 1'b1;
		left_in <= l[8:0];
		right_in <= r[8:0];
		gen_in <= g[11:0];
		@(posedge clk);
		sample <= 1'b0;
		prev_l = cur_l;
		cur_l = l;
		prev_r = cur_r;
		cur_r = r;
		prev_g = cur_g;
		cur_g = (gen_en_m != 0) ? g : 0;
	endtask

	// first output 3 clocks after the strobe edge, then one every TICK_DIV clocks
	task automatic collect(input string name, input int count);
		int waited;
		int p;
		int g_i;
		int amp;
		for (p = 0; p < count; p++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!out_valid && waited < 16);
			if (!out_valid) begin
				errors++;
				$display("%s: no output sample arrived for phase %0d", name, p);
			end
			check($sformatf("%s gap phase %0d", name, p), (p == 0) ? 3 : TICK_DIV, waited);
			g_i = interp(prev_g, cur_g, p);
			amp = gain(interp(prev_l, cur_l, p), g_i);
			if (saturate(amp) != amp) begin
				clip_m = 1;
			end
			check($sformatf("%s left phase %0d", name, p), saturate(amp), int'(left_out));
			amp = gain(interp(prev_r, cur_r, p), g_i);
			if (saturate(amp) != amp) begin
				clip_m = 1;
			end
			check($sformatf("%s right phase %0d", name, p), saturate(amp), int'(right_out));
		end
	endtask

	task automatic send_sample(input string name, input int l, input int r, input int g);
		strobe(l, r, g);
		collect(name, OSR);
		// keep the next strobe at least OSR * TICK_DIV clocks after this one
		repeat (OSR * TICK_DIV - 28) @(posedge clk);
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	task automatic register_access();
		int start;
		int rd;
		start = errors;
		// upper bits of the written bytes must not show up on reads
		wb_write(ADDR_VOLUME, 'hfd);
		wb_write(ADDR_CTRL, 'hff);
		wb_read(ADDR_VOLUME, rd);
		check("registers volume", 5, rd);
		wb_read(ADDR_CTRL, rd);
		check("registers ctrl", 1, rd);
		wb_read(ADDR_STATUS, rd);
		check("registers status", 0, rd);
		wb_read(3, rd);
		check("registers unmapped", 0, rd);
		wb_write(ADDR_VOLUME, 0);
		wb_write(ADDR_CTRL, 0);
		report_test("registers", start);
	endtask

	task automatic interpolation_steps();
		int start;
		int i;
		start = errors;
		for (i = 0; i < 8; i++) begin
			send_sample("interp", rand_fm(), rand_fm(), int'($urandom % 4096));
		end
		report_test("interp", start);
	endtask

	task automatic generator_mixing();
		int start;
		int i;
		start = errors;
		wb_write(ADDR_CTRL, 1);
		for (i = 0; i < 4; i++) begin
			send_sample("generator", 40, -40, int'($urandom % 4096));
		end
		// the gated generator ramps to zero over one sample and stays there
		wb_write(ADDR_CTRL, 0);
		for (i = 0; i < 2; i++) begin
			send_sample("generator off", 40, -40, int'($urandom % 4096));
		end
		check("generator settled", 40, int'(left_out));
		report_test("generator", start);
	endtask

	task automatic volume_sweep();
		int start;
		int v;
		int rd;
		start = errors;
		// left mixes to 382, which only clips at the top volume
		wb_write(ADDR_CTRL, 1);
		send_sample("volume settle", 255, -200, 4095);
		send_sample("volume settle", 255, -200, 4095);
		for (v = 0; v < 8; v++) begin
			wb_write(ADDR_VOLUME, v);
			send_sample($sformatf("volume %0d", v), 255, -200, 4095);
		end
		wb_read(ADDR_STATUS, rd);
		check("volume clip set", 1, rd);
		wb_write(ADDR_STATUS, 0);
		wb_read(ADDR_STATUS, rd);
		check("volume clip cleared", clip_m, rd);
		wb_write(ADDR_VOLUME, 0);
		wb_write(ADDR_CTRL, 0);
		report_test("volume", start);
	endtask

	// the second strobe lands after phase 1 so the old phases 2 and 3 never appear
	task automatic restart_midway();
		int start;
		start = errors;
		strobe(rand_fm(), rand_fm(), 0);
		collect("restart old", 2);
		send_sample("restart new", rand_fm(), rand_fm(), 0);
		report_test("restart", start);
	endtask

	initial begin
		void'($urandom(7822));
		arst_n <= 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		dat_w <= '0;
		sample <= 1'b0;
		left_in <= '0;
		right_in <= '0;
		gen_in <= '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		register_access();
		interpolation_steps();
		generator_mixing();
		volume_sweep();
		restart_midway();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- tb.f
source/mix_pkg.sv
source/mix_regs.sv
source/tick_timer.sv
source/interp_ctrl.sv
source/lin_interp.sv
source/gain_stage.sv
source/audio_mixer.sv
sim/audio_mixer_sva.sv
sim/tb_audio_mixer.sv

//--- Makefile
# Verilator build and run of the audio mixer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test    build with Verilator, run the testbench and check $(LOG)"
	@echo "make clean   remove the build directory and the log"
	@echo "make help    show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_audio_mixer -Mdir obj_dir
	./obj_dir/Vtb_audio_mixer > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG) || ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
